// ==== vreg_file.f ====
source/vreg_pkg.sv
source/vreg_element_locator.sv
source/vreg_read_port.sv
source/vreg_storage.sv
source/vreg_file.sv
tb/vreg_file_checker.sv
tb/vreg_file_assertions.sv
tb/vreg_file_tb.sv

// ==== tb/vreg_file_tb.sv ====
// --------------------------------------------------
// drives inputs on the falling edge, checker compares
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_file_tb;
  import vreg_pkg::*;

  logic CLK = 1'b0;
  logic nRST, wen;
  sew_t eew, sew, vs2_sew;
  logic [4:0] vd, vs1, vs2, vs3;
  logic [6:0] vd_offset, vs1_offset, vs2_offset, vs3_offset;
  logic [7:0] vl;
  lane_data_t w_data, vs1_data, vs2_data, vs3_data;
  logic [1:0] vs1_mask, vs2_mask, vs3_mask;
  integer seed = 32'hfa48_6dce;
  logic done = 1'b0;

  vreg_file i_vreg_file (.*);
  vreg_file_checker i_checker (.*);

  initial begin
    forever #5 CLK = ~CLK;
  end

  // bounded wait for the next falling edge
  task automatic next_falling_edge();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < 4 && !seen; i++) begin
      @(CLK);
      seen = (CLK == 1'b0);
    end
    if (!seen) begin
      $display("timeout: no falling clock edge seen");
      $display("Testbench failed");
      $finish;
    end
  endtask

  task automatic write_elem(input sew_t w, input int r, input int off, input int len);
    wen = 1'b1;
    eew = w;
    vd = r;
    vd_offset = off;
    vl = len;
    w_data = {$random(seed), $random(seed)};
    next_falling_edge();
    wen = 1'b0;
  endtask

  task automatic read_ports(input sew_t s, input sew_t s2, input int r, input int off);
    sew = s;
    vs2_sew = s2;
    vs1 = r;
    vs2 = r + 1;
    vs3 = r;
    vs1_offset = off;
    vs2_offset = off;
    vs3_offset = off + 3;
    next_falling_edge();
  endtask

  task automatic random_reads();
    sew = sew_t'($random(seed));
    vs2_sew = sew_t'($random(seed));
    {vs1, vs2, vs3} = $random(seed);
    {vs1_offset, vs2_offset, vs3_offset} = $random(seed);
    next_falling_edge();
  endtask

  initial begin
    nRST = 1'b0;
    {wen, vd, vd_offset, vl, w_data} = '0;
    {vs1, vs2, vs3, vs1_offset, vs2_offset, vs3_offset} = '0;
    eew = SEW8;
    sew = SEW8;
    vs2_sew = SEW8;
    repeat (3) next_falling_edge();
    nRST = 1'b1;
    for (int r = 0; r < 32; r++)
      for (int w = 0; w < 4; w++) read_ports(sew_t'(w), sew_t'(w), r, $random(seed));
    i_checker.report_test("reset clears all registers");
    for (int o = 0; o < 8; o++) write_elem(SEW32, 4, o, 8);
    for (int o = 0; o < 8; o++) read_ports(SEW32, SEW32, 4, o);
    i_checker.report_test("sew32 fill with lane 1 crossing");
    for (int o = 0; o < 10; o++) write_elem(SEW16, 8, o, 128);
    write_elem(SEW8, 8, 3, 128);
    write_elem(SEW8, 8, 20, 128);
    for (int o = 0; o < 16; o++) read_ports(sew_t'(o % 3), sew_t'((o + 1) % 3), 8, o);
    i_checker.report_test("sew16 and sew8 packing");
    for (int o = 0; o < 8; o++) write_elem(SEW32, 12, o, 8);
    write_elem(SEW32, 12, 4, 5);
    write_elem(SEW32, 12, 6, 5);
    write_elem(SEW8, 12, 127, 128);
    for (int o = 0; o < 8; o++) read_ports(SEW32, SEW8, 12, o);
    i_checker.report_test("vl cutoff");
    for (int i = 0; i < 40; i++) write_elem(SEW8, $random(seed), $random(seed), 128);
    for (int i = 0; i < 40; i++) random_reads();
    i_checker.report_test("mask bits");
    for (int i = 0; i < 300; i++) begin
      wen = $random(seed);
      eew = sew_t'($random(seed));
      {vd, vd_offset} = $random(seed);
      vl = $unsigned($random(seed)) % 129;
      w_data = {$random(seed), $random(seed)};
      random_reads();
    end
    wen = 1'b0;
    next_falling_edge();
    i_checker.report_test("random traffic");
    i_checker.summarize();
    done = 1'b1;
    if (i_checker.total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // whole-run limit
  initial begin
    for (int i = 0; i < 2000 && !done; i++) #100;
    if (!done) begin
      $display("timeout: run did not finish in time");
      $display("Testbench failed");
      $finish;
    end
  end

endmodule

// ==== tb/vreg_file_assertions.sv ====
// --------------------------------------------------
// bound into vreg_file, sees its internal regs array
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_file_assertions (
  input logic CLK, nRST, wen,
  input vreg_pkg::sew_t eew, sew, vs2_sew,
  input vreg_pkg::lane_data_t vs1_data, vs2_data, vs3_data,
  input vreg_pkg::vreg_array_t regs
);
  import vreg_pkg::*;

  // no write strobe or a reserved width leaves the array alone
  assert property (@(posedge CLK) disable iff (!nRST) (!wen || eew == SEW_RSVD) |=> $stable(regs))
    else $error("register array changed without a valid write");

  assert property (@(posedge CLK) disable iff (!nRST) sew == SEW8 |->
      vs1_data[0][31:8] == 0 && vs1_data[1][31:8] == 0 &&
      vs3_data[0][31:8] == 0 && vs3_data[1][31:8] == 0)
    else $error("sew8 read data not zero-extended");

  assert property (@(posedge CLK) disable iff (!nRST) sew == SEW16 |->
      vs1_data[0][31:16] == 0 && vs1_data[1][31:16] == 0 &&
      vs3_data[0][31:16] == 0 && vs3_data[1][31:16] == 0)
    else $error("sew16 read data not zero-extended");

  assert property (@(posedge CLK) disable iff (!nRST) vs2_sew != SEW32 |->
      vs2_data[0][31:16] == 0 && vs2_data[1][31:16] == 0)
    else $error("vs2 narrow read data not zero-extended");

endmodule

bind vreg_file vreg_file_assertions i_assertions (.*);

// ==== tb/vreg_file_checker.sv ====
// --------------------------------------------------
// shadow model, compares 2 ns after each falling edge
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_file_checker (
  input logic CLK, nRST, wen,
  input vreg_pkg::sew_t eew, sew, vs2_sew,
  input logic [4:0] vd, vs1, vs2, vs3,
  input logic [6:0] vd_offset, vs1_offset, vs2_offset, vs3_offset,
  input logic [7:0] vl,
  input vreg_pkg::lane_data_t w_data, vs1_data, vs2_data, vs3_data,
  input logic [1:0] vs1_mask, vs2_mask, vs3_mask
);
  import vreg_pkg::*;

  logic [7:0] shadow [0:31][0:15];
  int checks, errors, total_errors, tests, failed_tests;

  // element k of a group: register, byte position, zero-extended value
  function automatic logic [31:0] ref_elem(int base, int offset, int s, int k);
    int eb, epr, off, r, bp;
    logic [31:0] v;
    v = '0;
    if (s == 3) return v;
    eb = 1 << s;
    epr = 16 / eb;
    off = (offset + k) % 128;
    r = (base + (off / epr) % 8) % 32;
    bp = (off % epr) * eb;
    for (int b = 0; b < eb; b++) v[8*b +: 8] = shadow[r][bp + b];
    return v;
  endfunction

  function automatic logic ref_mask(int base, int offset, int k);
    int off;
    off = (offset + k) % 128;
    return shadow[base][off / 8][off % 8];
  endfunction

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      foreach (shadow[r, b]) shadow[r][b] = 8'h00;
    end else if (wen && eew != SEW_RSVD) begin
      for (int k = 0; k < 2; k++) begin
        int eb, epr, off, r, bp;
        eb = 1 << eew;
        epr = 16 / eb;
        off = (vd_offset + k) % 128;
        r = (vd + (off / epr) % 8) % 32;
        bp = (off % epr) * eb;
        if (vd_offset + k < vl)
          for (int b = 0; b < eb; b++) shadow[r][bp + b] = w_data[k][8*b +: 8];
      end
    end
  end

  task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h got %h at %0t", name, exp, act, $time);
    end
  endtask

  always @(negedge CLK) begin
    #2;
    if (nRST) begin
      check_val("vs1_data", {ref_elem(vs1, vs1_offset, sew, 1), ref_elem(vs1, vs1_offset, sew, 0)},
                vs1_data);
      check_val("vs2_data", {ref_elem(vs2, vs2_offset, vs2_sew, 1),
                             ref_elem(vs2, vs2_offset, vs2_sew, 0)}, vs2_data);
      check_val("vs3_data", {ref_elem(vs3, vs3_offset, sew, 1), ref_elem(vs3, vs3_offset, sew, 0)},
                vs3_data);
      check_val("vs1_mask", {ref_mask(vs1, vs1_offset, 1), ref_mask(vs1, vs1_offset, 0)}, vs1_mask);
      check_val("vs2_mask", {ref_mask(vs2, vs2_offset, 1), ref_mask(vs2, vs2_offset, 0)}, vs2_mask);
      check_val("vs3_mask", {ref_mask(vs3, vs3_offset, 1), ref_mask(vs3, vs3_offset, 0)}, vs3_mask);
    end
  end

  task automatic report_test(string name);
    tests++;
    if (errors != 0) begin
      failed_tests++;
    end
    $display("%s %s: %0d checks, %0d errors", errors == 0 ? "ok  " : "FAIL", name, checks, errors);
    total_errors += errors;
    checks = 0;
    errors = 0;
  endtask

  task automatic summarize();
    $display("tests passed %0d, failed %0d, total errors %0d",
             tests - failed_tests, failed_tests, total_errors);
  endtask

endmodule

// ==== source/vreg_file.sv ====
// --------------------------------------------------
// 32 x 128-bit vector registers, 1 write, 3 reads
// vs1 and vs3 share sew, vs2 has its own width
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_file (
  input  logic                           CLK,
  input  logic                           nRST,
  // write side
  input  logic                           wen,
  input  vreg_pkg::sew_t                 eew,
  input  logic [vreg_pkg::REG_IDX_W-1:0] vd,
  input  logic [vreg_pkg::OFFSET_W-1:0]  vd_offset,
  input  logic [vreg_pkg::VL_W-1:0]      vl,
  input  vreg_pkg::lane_data_t           w_data,
  // read side
  input  vreg_pkg::sew_t                 sew,
  input  vreg_pkg::sew_t                 vs2_sew,
  input  logic [vreg_pkg::REG_IDX_W-1:0] vs1,
  input  logic [vreg_pkg::REG_IDX_W-1:0] vs2,
  input  logic [vreg_pkg::REG_IDX_W-1:0] vs3,
  input  logic [vreg_pkg::OFFSET_W-1:0]  vs1_offset,
  input  logic [vreg_pkg::OFFSET_W-1:0]  vs2_offset,
  input  logic [vreg_pkg::OFFSET_W-1:0]  vs3_offset,
  output vreg_pkg::lane_data_t           vs1_data,
  output vreg_pkg::lane_data_t           vs2_data,
  output vreg_pkg::lane_data_t           vs3_data,
  output logic [vreg_pkg::LANES-1:0]     vs1_mask,
  output logic [vreg_pkg::LANES-1:0]     vs2_mask,
  output logic [vreg_pkg::LANES-1:0]     vs3_mask
);
  import vreg_pkg::*;

  logic [LANES-1:0][REG_IDX_W-1:0]  wr_reg_idx;
  logic [LANES-1:0][BYTE_POS_W-1:0] wr_byte_pos;
  logic [LANES-1:0][OFFSET_W-1:0]   wr_lane_offset;

  logic [LANES-1:0][REG_IDX_W-1:0]  vs1_reg_idx;
  logic [LANES-1:0][BYTE_POS_W-1:0] vs1_byte_pos;
  logic [LANES-1:0][OFFSET_W-1:0]   vs1_lane_offset;

  logic [LANES-1:0][REG_IDX_W-1:0]  vs2_reg_idx;
  logic [LANES-1:0][BYTE_POS_W-1:0] vs2_byte_pos;
  logic [LANES-1:0][OFFSET_W-1:0]   vs2_lane_offset;

  logic [LANES-1:0][REG_IDX_W-1:0]  vs3_reg_idx;
  logic [LANES-1:0][BYTE_POS_W-1:0] vs3_byte_pos;
  logic [LANES-1:0][OFFSET_W-1:0]   vs3_lane_offset;

  vreg_array_t regs;

  // write path
  vreg_element_locator i_wr_locator (
    .sew         (eew),
    .base        (vd),
    .offset      (vd_offset),
    .reg_idx     (wr_reg_idx),
    .byte_pos    (wr_byte_pos),
    .lane_offset (wr_lane_offset)
  );

  vreg_storage i_storage (
    .CLK         (CLK),
    .nRST        (nRST),
    .wen         (wen),
    .eew         (eew),
    .reg_idx     (wr_reg_idx),
    .byte_pos    (wr_byte_pos),
    .lane_offset (wr_lane_offset),
    .vl          (vl),
    .w_data      (w_data),
    .regs        (regs)
  );

  // vs1 port
  vreg_element_locator i_vs1_locator (
    .sew         (sew),
    .base        (vs1),
    .offset      (vs1_offset),
    .reg_idx     (vs1_reg_idx),
    .byte_pos    (vs1_byte_pos),
    .lane_offset (vs1_lane_offset)
  );

  vreg_read_port i_vs1_port (
    .regs        (regs),
    .sew         (sew),
    .base        (vs1),
    .reg_idx     (vs1_reg_idx),
    .byte_pos    (vs1_byte_pos),
    .lane_offset (vs1_lane_offset),
    .data        (vs1_data),
    .mask        (vs1_mask)
  );

  // vs2 port, own width
  vreg_element_locator i_vs2_locator (
    .sew         (vs2_sew),
    .base        (vs2),
    .offset      (vs2_offset),
    .reg_idx     (vs2_reg_idx),
    .byte_pos    (vs2_byte_pos),
    .lane_offset (vs2_lane_offset)
  );

  vreg_read_port i_vs2_port (
    .regs        (regs),
    .sew         (vs2_sew),
    .base        (vs2),
    .reg_idx     (vs2_reg_idx),
    .byte_pos    (vs2_byte_pos),
    .lane_offset (vs2_lane_offset),
    .data        (vs2_data),
    .mask        (vs2_mask)
  );

  // vs3 port
  vreg_element_locator i_vs3_locator (
    .sew         (sew),
    .base        (vs3),
    .offset      (vs3_offset),
    .reg_idx     (vs3_reg_idx),
    .byte_pos    (vs3_byte_pos),
    .lane_offset (vs3_lane_offset)
  );

  vreg_read_port i_vs3_port (
    .regs        (regs),
    .sew         (sew),
    .base        (vs3),
    .reg_idx     (vs3_reg_idx),
    .byte_pos    (vs3_byte_pos),
    .lane_offset (vs3_lane_offset),
    .data        (vs3_data),
    .mask        (vs3_mask)
  );

endmodule

// ==== source/vreg_storage.sv ====
// --------------------------------------------------
// single two-lane write port, no handshake
// lanes at or past vl and a reserved eew write nothing
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_storage (
  input  logic                                                 CLK,
  input  logic                                                 nRST,
  input  logic                                                 wen,
  input  vreg_pkg::sew_t                                       eew,
  input  logic [vreg_pkg::LANES-1:0][vreg_pkg::REG_IDX_W-1:0]  reg_idx,
  input  logic [vreg_pkg::LANES-1:0][vreg_pkg::BYTE_POS_W-1:0] byte_pos,
  input  logic [vreg_pkg::LANES-1:0][vreg_pkg::OFFSET_W-1:0]   lane_offset,
  input  logic [vreg_pkg::VL_W-1:0]                            vl,
  input  vreg_pkg::lane_data_t                                 w_data,
  output vreg_pkg::vreg_array_t                                regs
);
  import vreg_pkg::*;

  vreg_array_t      next_regs;
  logic [LANES-1:0] lane_en;
  logic             write_ok;

  assign write_ok = wen && (eew != SEW_RSVD);

  // per-lane vl check
  always_comb begin
    lane_en[0] = VL_W'(lane_offset[0]) < vl;
    // offset 127 wraps lane 1 to zero, which is element 128 and past any vl
    lane_en[1] = (lane_offset[1] != '0) && (VL_W'(lane_offset[1]) < vl);
  end

  // byte merge, only the element's bytes change
  always_comb begin
    next_regs = regs;
    for (int k = 0; k < LANES; k++) begin
      if (lane_en[k]) begin
        case (eew)
          SEW32: begin
            next_regs[reg_idx[k]][byte_pos[k] +: 4] = w_data[k][31:0];
          end
          SEW16: begin
            next_regs[reg_idx[k]][byte_pos[k] +: 2] = w_data[k][15:0];
          end
          SEW8: begin
            next_regs[reg_idx[k]][byte_pos[k]] = w_data[k][7:0];
          end
          default: begin
            // reserved width, no bytes change
          end
        endcase
      end
    end
  end

  // visible on reads the cycle after the edge that took it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '0;
    end else if (write_ok) begin
      regs <= next_regs;
    end
  end

endmodule

// ==== source/vreg_read_port.sv ====
// --------------------------------------------------
// combinational read, data returned regardless of vl
// mask bits always come from the base register
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_read_port (
  input  vreg_pkg::vreg_array_t                                regs,
  input  vreg_pkg::sew_t                                       sew,
  input  logic [vreg_pkg::REG_IDX_W-1:0]                       base,
  input  logic [vreg_pkg::LANES-1:0][vreg_pkg::REG_IDX_W-1:0]  reg_idx,
  input  logic [vreg_pkg::LANES-1:0][vreg_pkg::BYTE_POS_W-1:0] byte_pos,
  input  logic [vreg_pkg::LANES-1:0][vreg_pkg::OFFSET_W-1:0]   lane_offset,
  output vreg_pkg::lane_data_t                                 data,
  output logic [vreg_pkg::LANES-1:0]                           mask
);
  import vreg_pkg::*;

  // element gather, zero-extended to the lane width
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      case (sew)
        SEW32: begin
          data[k] = regs[reg_idx[k]][byte_pos[k] +: 4];
        end
        SEW16: begin
          data[k] = {16'h0000, regs[reg_idx[k]][byte_pos[k] +: 2]};
        end
        SEW8: begin
          data[k] = {24'h00_0000, regs[reg_idx[k]][byte_pos[k]]};
        end
        default: begin
          data[k] = '0;
        end
      endcase
    end
  end

  // one mask bit per element number
  // byte is offset div 8, bit is offset mod 8, no group stepping
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      mask[k] = regs[base][lane_offset[k][OFFSET_W-1:3]][lane_offset[k][2:0]];
    end
  end

endmodule

// ==== source/vreg_element_locator.sv ====
// --------------------------------------------------
// groups span at most 8 registers, index wraps at 32
// reserved width gives index and position zero
// --------------------------------------------------
`timescale 1ns/10ps

module vreg_element_locator (
  input  vreg_pkg::sew_t                                     sew,
  input  logic [vreg_pkg::REG_IDX_W-1:0]                     base,
  input  logic [vreg_pkg::OFFSET_W-1:0]                      offset,
  output logic [vreg_pkg::LANES-1:0][vreg_pkg::REG_IDX_W-1:0]  reg_idx,
  output logic [vreg_pkg::LANES-1:0][vreg_pkg::BYTE_POS_W-1:0] byte_pos,
  output logic [vreg_pkg::LANES-1:0][vreg_pkg::OFFSET_W-1:0]   lane_offset
);
  import vreg_pkg::*;

  // lane 1 element number wraps at 7 bits
  assign lane_offset[0] = offset;
  assign lane_offset[1] = offset + 1'b1;

  // quotient keeps 3 bits, so a lane steps at most 7 registers past base
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      case (sew)
        SEW32: begin
          reg_idx[k]  = base + {2'b00, lane_offset[k][4:2]};
          byte_pos[k] = {lane_offset[k][1:0], 2'b00};
        end
        SEW16: begin
          reg_idx[k]  = base + {2'b00, lane_offset[k][5:3]};
          byte_pos[k] = {lane_offset[k][2:0], 1'b0};
        end
        SEW8: begin
          reg_idx[k]  = base + {2'b00, lane_offset[k][6:4]};
          byte_pos[k] = lane_offset[k][3:0];
        end
        default: begin
          reg_idx[k]  = '0;
          byte_pos[k] = '0;
        end
      endcase
    end
  end

endmodule

// ==== source/vreg_pkg.sv ====
// --------------------------------------------------
// vector register file widths and types, VLEN 128
// element widths 8/16/32 only, fourth code reserved
// --------------------------------------------------
package vreg_pkg;

  // register array shape
  localparam int NUM_VREGS  = 32;
  localparam int REG_IDX_W  = $clog2(NUM_VREGS);
  localparam int VREG_BYTES = 16;
  localparam int BYTE_POS_W = $clog2(VREG_BYTES);

  // element addressing, vl runs 0 to 128
  localparam int OFFSET_W = 7;
  localparam int VL_W     = 8;

  // two lanes per access, each up to 32 bits
  localparam int LANES  = 2;
  localparam int ELEM_W = 32;

  typedef enum logic [1:0] {
    SEW8     = 2'b00,
    SEW16    = 2'b01,
    SEW32    = 2'b10,
    SEW_RSVD = 2'b11
  } sew_t;

  // one register as bytes, byte 0 in the low bits
  typedef logic [VREG_BYTES-1:0][7:0] vreg_t;

  typedef vreg_t [NUM_VREGS-1:0] vreg_array_t;

  // lane 0 is the element at the offset, lane 1 the next one
  typedef logic [LANES-1:0][ELEM_W-1:0] lane_data_t;

endpackage
